//--- src/rv_core_params.svh
//################################################
// Core-wide sizes. XLEN other than 32 is not supported
// Data memory size must be a power of two
//################################################
`ifndef RV_CORE_PARAMS_SVH
`define RV_CORE_PARAMS_SVH

`define XLEN        32
`define REG_COUNT   32
`define DMEM_BYTES  4096
`define RESET_PC    32'h0000_0000

`endif

//--- src/rv_core_pkg.sv
//################################################
// Types shared by the RV32I core
// Enum encodings follow the RV32I opcode map
//################################################
`include "rv_core_params.svh"

package rv_core_pkg;

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [4:0]       reg_idx_t;

    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111
    } opcode_t;

    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND
    } alu_op_t;

    typedef enum logic [1:0] {
        PC_PLUS4, PC_BRANCH, PC_JAL, PC_JALR
    } pc_src_t;

    typedef enum logic [2:0] {
        WB_ALU, WB_LOAD, WB_LINK, WB_IMM, WB_PC_IMM
    } wb_src_t;

    // Matches funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        BYTE = 2'b00,
        HALF = 2'b01,
        WORD = 2'b10
    } mem_size_t;

endpackage

//--- src/fetch_unit.sv
//################################################
// PC advances every cycle, no stall
// JALR target has bit 0 cleared
//################################################
`timescale 1ns/1ns
`include "rv_core_params.svh"

module fetch_unit (
    input  logic                 clk,
    input  logic                 reset,
    input  rv_core_pkg::pc_src_t pc_src,
    input  logic                 branch_taken,
    input  rv_core_pkg::word_t   imm,
    input  rv_core_pkg::word_t   rs1_data,
    output rv_core_pkg::word_t   pc,
    output rv_core_pkg::word_t   pc_plus4
);
    import rv_core_pkg::*;

    word_t pc_imm;
    word_t jalr_target;
    word_t next_pc;

    assign pc_plus4    = pc + `XLEN'd4;
    assign pc_imm      = pc + imm;                             // Branch and JAL target
    assign jalr_target = (rs1_data + imm) & ~`XLEN'd1;

    always_comb begin
        case (pc_src)
            PC_BRANCH: next_pc = branch_taken ? pc_imm : pc_plus4;
            PC_JAL:    next_pc = pc_imm;
            PC_JALR:   next_pc = jalr_target;
            default:   next_pc = pc_plus4;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            pc <= `RESET_PC;
        else
            pc <= next_pc;
    end

endmodule

//--- src/instr_decoder.sv
//################################################
// Unknown opcodes (FENCE, ECALL, CSR) decode as
// no-ops: no register write, no store, PC+4
//################################################
`timescale 1ns/1ns

module instr_decoder (
    input  rv_core_pkg::word_t     instr,
    input  logic                   reset,
    output rv_core_pkg::reg_idx_t  rs1_addr,
    output rv_core_pkg::reg_idx_t  rs2_addr,
    output rv_core_pkg::reg_idx_t  rd_addr,
    output rv_core_pkg::word_t     imm,
    output rv_core_pkg::alu_op_t   alu_op,
    output logic                   alu_use_imm,
    output rv_core_pkg::pc_src_t   pc_src,
    output rv_core_pkg::wb_src_t   wb_src,
    output logic                   reg_write,
    output logic                   mem_read,
    output logic                   mem_write,
    output rv_core_pkg::mem_size_t mem_size,
    output logic                   load_unsigned,
    output logic [2:0]             branch_cond
);
    import rv_core_pkg::*;

    opcode_t    opcode;
    logic [2:0] funct3;
    alu_op_t    f3_op;
    logic       writes_rd;
    logic       is_store;

    assign opcode   = opcode_t'(instr[6:0]);
    assign funct3   = instr[14:12];
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];
    assign rd_addr  = instr[11:7];

    assign branch_cond   = funct3;
    assign mem_size      = mem_size_t'(funct3[1:0]);
    assign load_unsigned = funct3[2];

    // funct3 to ALU op, bit 30 picks SUB/SRA
    always_comb begin
        case (funct3)
            3'b001:  f3_op = SLL;
            3'b010:  f3_op = SLT;
            3'b011:  f3_op = SLTU;
            3'b100:  f3_op = XOR;
            3'b101:  f3_op = instr[30] ? SRA : SRL;
            3'b110:  f3_op = OR;
            3'b111:  f3_op = AND;
            default: f3_op = ADD;
        endcase
    end

    always_comb begin
        imm         = '0;
        alu_op      = ADD;
        alu_use_imm = 1'b0;
        pc_src      = PC_PLUS4;
        wb_src      = WB_ALU;
        writes_rd   = 1'b0;
        mem_read    = 1'b0;
        is_store    = 1'b0;
        case (opcode)
            OP: begin
                alu_op    = (funct3 == 3'b000 && instr[30]) ? SUB : f3_op;
                writes_rd = 1'b1;
            end
            OP_IMM: begin
                imm         = {{20{instr[31]}}, instr[31:20]};
                alu_op      = f3_op;                           // No SUBI
                alu_use_imm = 1'b1;
                writes_rd   = 1'b1;
            end
            LOAD: begin
                imm         = {{20{instr[31]}}, instr[31:20]};
                alu_use_imm = 1'b1;
                wb_src      = WB_LOAD;
                writes_rd   = 1'b1;
                mem_read    = 1'b1;
            end
            STORE: begin
                imm         = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                alu_use_imm = 1'b1;
                is_store    = 1'b1;
            end
            BRANCH: begin
                imm    = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
                pc_src = PC_BRANCH;
            end
            JAL: begin
                imm       = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
                pc_src    = PC_JAL;
                wb_src    = WB_LINK;
                writes_rd = 1'b1;
            end
            JALR: begin
                imm       = {{20{instr[31]}}, instr[31:20]};
                pc_src    = PC_JALR;
                wb_src    = WB_LINK;
                writes_rd = 1'b1;
            end
            LUI: begin
                imm       = {instr[31:12], 12'b0};
                wb_src    = WB_IMM;
                writes_rd = 1'b1;
            end
            AUIPC: begin
                imm       = {instr[31:12], 12'b0};
                wb_src    = WB_PC_IMM;
                writes_rd = 1'b1;
            end
            default: ;                                         // No-op
        endcase
    end

    assign reg_write = writes_rd && (rd_addr != '0) && !reset;
    assign mem_write = is_store && !reset;

endmodule

//--- src/register_file.sv
//################################################
// x0 always reads zero and is never written
// Reads are combinational, writes on rising edge
//################################################
`timescale 1ns/1ns
`include "rv_core_params.svh"

module register_file (
    input  logic                  clk,
    input  logic                  reset,
    input  rv_core_pkg::reg_idx_t rs1_addr,
    input  rv_core_pkg::reg_idx_t rs2_addr,
    input  rv_core_pkg::reg_idx_t rd_addr,
    input  logic                  write,
    input  rv_core_pkg::word_t    write_data,
    output rv_core_pkg::word_t    rs1_data,
    output rv_core_pkg::word_t    rs2_data
);
    import rv_core_pkg::*;

    word_t regs [`REG_COUNT];

    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++)
                regs[i] <= '0;
        end else if (write && rd_addr != '0) begin
            regs[rd_addr] <= write_data;
        end
    end

endmodule

//--- src/alu.sv
//################################################
// Shift amount is b[4:0]
// branch_taken is valid only for B-type funct3
//################################################
`timescale 1ns/1ns

module alu (
    input  rv_core_pkg::word_t   a,
    input  rv_core_pkg::word_t   b,
    input  rv_core_pkg::alu_op_t op,
    input  logic [2:0]           branch_cond,
    output rv_core_pkg::word_t   result,
    output logic                 branch_taken
);
    import rv_core_pkg::*;

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;

    assign shamt = b[4:0];
    assign lt_s  = $signed(a) < $signed(b);
    assign lt_u  = a < b;

    always_comb begin
        case (op)
            SUB:     result = a - b;
            SLL:     result = a << shamt;
            SLT:     result = word_t'(lt_s);
            SLTU:    result = word_t'(lt_u);
            XOR:     result = a ^ b;
            SRL:     result = a >> shamt;
            SRA:     result = word_t'($signed(a) >>> shamt);
            OR:      result = a | b;
            AND:     result = a & b;
            default: result = a + b;
        endcase
    end

    always_comb begin
        case (branch_cond)
            3'b000:  branch_taken = (a == b);                  // BEQ
            3'b001:  branch_taken = (a != b);                  // BNE
            3'b100:  branch_taken = lt_s;
            3'b101:  branch_taken = !lt_s;
            3'b110:  branch_taken = lt_u;
            3'b111:  branch_taken = !lt_u;
            default: branch_taken = 1'b0;
        endcase
    end

endmodule

//--- src/data_memory.sv
//################################################
// Little-endian, address wraps modulo DMEM_BYTES
// Misaligned accesses are not supported
// Contents are not cleared by reset
//################################################
`timescale 1ns/1ns
`include "rv_core_params.svh"

module data_memory (
    input  logic                   clk,
    input  rv_core_pkg::word_t     addr,
    input  rv_core_pkg::word_t     write_data,
    input  logic                   mem_read,
    input  logic                   mem_write,
    input  rv_core_pkg::mem_size_t mem_size,
    input  logic                   load_unsigned,
    output rv_core_pkg::word_t     load_data
);
    import rv_core_pkg::*;

    localparam int AW = $clog2(`DMEM_BYTES);

    logic [7:0]    mem [`DMEM_BYTES];
    logic [AW-1:0] idx0, idx1, idx2, idx3;
    logic [7:0]    b0, b1, b2, b3;

    assign idx0 = addr[AW-1:0];
    assign idx1 = idx0 + AW'(1);
    assign idx2 = idx0 + AW'(2);
    assign idx3 = idx0 + AW'(3);

    assign b0 = mem[idx0];
    assign b1 = mem[idx1];
    assign b2 = mem[idx2];
    assign b3 = mem[idx3];

    always_comb begin
        load_data = '0;
        if (mem_read) begin
            case (mem_size)
                BYTE:    load_data = {{(`XLEN-8){b0[7] & ~load_unsigned}}, b0};
                HALF:    load_data = {{(`XLEN-16){b1[7] & ~load_unsigned}}, b1, b0};
                default: load_data = {b3, b2, b1, b0};
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (mem_write) begin
            mem[idx0] <= write_data[7:0];
            if (mem_size != BYTE)
                mem[idx1] <= write_data[15:8];
            if (mem_size == WORD) begin
                mem[idx2] <= write_data[23:16];
                mem[idx3] <= write_data[31:24];
            end
        end
    end

endmodule

//--- src/rv_core.sv
//################################################
// Single-cycle RV32I, one instruction per clock
// instr must be valid while pc holds its address
// rd_* report the write that lands at the next edge
//################################################
`timescale 1ns/1ns

module rv_core (
    input  logic                  clk,
    input  logic                  reset,
    input  rv_core_pkg::word_t    instr,
    output rv_core_pkg::word_t    pc,
    output logic                  rd_write,
    output rv_core_pkg::reg_idx_t rd_addr,
    output rv_core_pkg::word_t    rd_data
);
    import rv_core_pkg::*;

    reg_idx_t   rs1_addr, rs2_addr;
    word_t      imm, rs1_data, rs2_data;
    word_t      pc_plus4, alu_b, alu_result, load_data;
    alu_op_t    alu_op;
    logic       alu_use_imm;
    pc_src_t    pc_src;
    wb_src_t    wb_src;
    logic       mem_read, mem_write, load_unsigned, branch_taken;
    mem_size_t  mem_size;
    logic [2:0] branch_cond;

    fetch_unit u_fetch (
        .clk(clk), .reset(reset), .pc_src(pc_src), .branch_taken(branch_taken),
        .imm(imm), .rs1_data(rs1_data), .pc(pc), .pc_plus4(pc_plus4)
    );

    instr_decoder u_decoder (
        .instr(instr), .reset(reset), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .rd_addr(rd_addr), .imm(imm), .alu_op(alu_op), .alu_use_imm(alu_use_imm),
        .pc_src(pc_src), .wb_src(wb_src), .reg_write(rd_write), .mem_read(mem_read),
        .mem_write(mem_write), .mem_size(mem_size), .load_unsigned(load_unsigned),
        .branch_cond(branch_cond)
    );

    register_file u_regs (
        .clk(clk), .reset(reset), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .rd_addr(rd_addr), .write(rd_write), .write_data(rd_data),
        .rs1_data(rs1_data), .rs2_data(rs2_data)
    );

    assign alu_b = alu_use_imm ? imm : rs2_data;

    alu u_alu (
        .a(rs1_data), .b(alu_b), .op(alu_op), .branch_cond(branch_cond),
        .result(alu_result), .branch_taken(branch_taken)
    );

    data_memory u_dmem (
        .clk(clk), .addr(alu_result), .write_data(rs2_data), .mem_read(mem_read),
        .mem_write(mem_write), .mem_size(mem_size), .load_unsigned(load_unsigned),
        .load_data(load_data)
    );

    always_comb begin
        case (wb_src)
            WB_LOAD:   rd_data = load_data;
            WB_LINK:   rd_data = pc_plus4;                     // JAL/JALR return address
            WB_IMM:    rd_data = imm;
            WB_PC_IMM: rd_data = pc + imm;                     // AUIPC
            default:   rd_data = alu_result;
        endcase
    end

endmodule

//--- testbench/tb_clock.sv
//################################################
// Free-running testbench clock, starts low
//################################################
`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD = 20
) (
    output logic clk
);
    initial clk = 1'b0;
    always #(PERIOD / 2) clk = ~clk;
endmodule

//--- testbench/rv_core_chk.sv
//################################################
// Protocol checks on the core's external outputs
// Sampled at the rising edge of clk
//################################################
`timescale 1ns/1ns

module rv_core_chk (
    input logic                  clk,
    input logic                  reset,
    input rv_core_pkg::word_t    pc,
    input logic                  rd_write,
    input rv_core_pkg::reg_idx_t rd_addr
);
    int fails = 0;                                             // Read by the testbench

    a_pc_aligned: assert property (@(posedge clk) pc[1:0] == 2'b00)
        else begin
            fails++;
            $error("pc %h is not word-aligned", pc);
        end

    a_no_x0_write: assert property (@(posedge clk) disable iff (reset) rd_write |-> rd_addr != '0)
        else begin
            fails++;
            $error("rd_write high with rd_addr zero");
        end

    a_quiet_in_reset: assert property (@(posedge clk) reset |-> !rd_write)
        else begin
            fails++;
            $error("rd_write high during reset");
        end
endmodule

bind rv_core rv_core_chk u_chk (
    .clk(clk), .reset(reset), .pc(pc), .rd_write(rd_write), .rd_addr(rd_addr)
);

//--- testbench/rv_core_tb.sv
//################################################
// Directed tests for the single-cycle core
// Instructions are driven at the falling edge and
// outputs checked 1 ns later; a shadow register
// array predicts every write
//################################################
`timescale 1ns/1ns
`include "rv_core_params.svh"

module rv_core_tb;
    import rv_core_pkg::*;

    localparam int RESET_CYCLES = 10;
    localparam int TEST_CYCLES  = 32 + 92 + 2 + 26 + 2 + 50;  // reset, alu, x0, branch, upper, mem
    localparam int CYCLE_LIMIT  = 2 * TEST_CYCLES + RESET_CYCLES;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam word_t      NOP        = 32'h0000_0013;      // addi x0, x0, 0

    logic     clk;
    logic     reset;
    word_t    instr;
    word_t    pc;
    logic     rd_write;
    reg_idx_t rd_addr;
    word_t    rd_data;

    word_t shadow [`REG_COUNT];
    word_t exp_pc;
    word_t seed = 32'hf666;
    int    errors = 0;
    int    checks = 0;
    int    cycles = 0;

    tb_clock clock_gen (.clk(clk));

    rv_core UUT (
        .clk(clk), .reset(reset), .instr(instr), .pc(pc),
        .rd_write(rd_write), .rd_addr(rd_addr), .rd_data(rd_data)
    );

    function automatic word_t lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic word_t enc_r(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                    logic [2:0] f3, reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic word_t enc_i(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
                                    reg_idx_t rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t enc_s(logic [11:0] imm, reg_idx_t rs2, reg_idx_t rs1,
                                    logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
    endfunction

    function automatic word_t enc_b(logic [12:0] imm, reg_idx_t rs2, reg_idx_t rs1,
                                    logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic word_t enc_u(logic [19:0] imm, reg_idx_t rd, logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic word_t enc_j(logic [20:0] imm, reg_idx_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    function automatic word_t sext12(logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // RV32I result by funct3, alt is instruction bit 30
    function automatic word_t alu_ref(logic [2:0] f3, logic alt, word_t a, word_t b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_ref(logic [2:0] f3, word_t a, word_t b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic check_word(string name, word_t got, word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got %h expected %h (pc %h)", name, got, exp, pc);
        end
    endtask

    task automatic check_idx(string name, reg_idx_t got, reg_idx_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got %h expected %h (pc %h)", name, got, exp, pc);
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got %h expected %h (pc %h)", name, got, exp, pc);
        end
    endtask

    // One instruction per cycle, pc checked on the way in
    task automatic step(word_t i);
        @(negedge clk);
        instr = i;
        #1;
        check_word("pc", pc, exp_pc);
        exp_pc = exp_pc + 32'd4;
    endtask

    task automatic expect_write(word_t i, reg_idx_t rd, word_t value);
        step(i);
        check_bit("rd_write", rd_write, 1'b1);
        check_idx("rd_addr", rd_addr, rd);
        check_word("rd_data", rd_data, value);
        shadow[rd] = value;
    endtask

    task automatic expect_no_write(word_t i);
        step(i);
        check_bit("rd_write", rd_write, 1'b0);
    endtask

    // LUI then ADDI, upper part rounded for the signed low 12 bits
    task automatic load_reg(reg_idx_t rd, word_t value);
        logic [19:0] upper;
        upper = 20'((value + 32'h800) >> 12);
        expect_write(enc_u(upper, rd, OPC_LUI), rd, {upper, 12'h000});
        expect_write(enc_i(value[11:0], rd, 3'b000, rd, OPC_OP_IMM), rd, value);
    endtask

    task automatic report(string name, int errors_before);
        $display("%s done, %0d errors", name, errors - errors_before);
    endtask

    task automatic test_reset();
        int start;
        start = errors;
        reset = 1'b1;
        instr = enc_i(12'd5, 5'd0, 3'b000, 5'd1, OPC_OP_IMM);  // Would write x1
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        check_word("pc", pc, `RESET_PC);
        check_bit("rd_write", rd_write, 1'b0);
        @(negedge clk);
        reset = 1'b0;
        instr = NOP;
        #1;
        check_word("pc", pc, `RESET_PC);
        check_bit("rd_write", rd_write, 1'b0);
        exp_pc = `RESET_PC + 32'd4;
        for (int r = 1; r < 32; r++) begin
            expect_write(enc_r(7'd0, reg_idx_t'(r % 31 + 1), reg_idx_t'(r), 3'b000,
                               reg_idx_t'(r)), reg_idx_t'(r), '0);
        end
        report("reset", start);
    endtask

    task automatic test_alu();
        int          start;
        word_t       a;
        word_t       b;
        word_t       r;
        logic [11:0] imm;
        logic [2:0]  f3;
        logic        alt;
        start = errors;
        for (int round = 0; round < 4; round++) begin
            a = lcg_next();
            b = lcg_next();
            load_reg(5'd5, a);
            load_reg(5'd6, b);
            for (int op = 0; op < 10; op++) begin
                f3  = (op < 8) ? 3'(op) : ((op == 8) ? 3'b000 : 3'b101);  // 8 SUB, 9 SRA
                alt = (op >= 8);
                expect_write(enc_r(alt ? 7'h20 : 7'h00, 5'd6, 5'd5, f3, 5'd10), 5'd10,
                             alu_ref(f3, alt, a, b));
                if (op != 8) begin
                    r   = lcg_next();
                    imm = r[11:0];
                    if (f3 == 3'b001 || f3 == 3'b101)
                        imm = {1'b0, alt, 5'b0, imm[4:0]};
                    expect_write(enc_i(imm, 5'd5, f3, 5'd11, OPC_OP_IMM), 5'd11,
                                 alu_ref(f3, alt, a, sext12(imm)));
                end
            end
        end
        report("alu", start);
    endtask

    task automatic test_x0();
        int start;
        start = errors;
        expect_no_write(enc_i(12'd123, 5'd5, 3'b000, 5'd0, OPC_OP_IMM));
        expect_write(enc_r(7'd0, 5'd0, 5'd0, 3'b000, 5'd12), 5'd12, '0);
        report("x0", start);
    endtask

    task automatic test_branch();
        int          start;
        word_t       base;
        word_t       off;
        word_t       r;
        reg_idx_t    ra;
        reg_idx_t    rb;
        logic [11:0] imm;
        logic [2:0]  f3;
        logic        taken;
        start = errors;
        load_reg(5'd5, lcg_next());
        load_reg(5'd6, lcg_next());
        for (int c = 0; c < 6; c++) begin
            f3 = (c < 2) ? 3'(c) : 3'(c + 2);
            for (int p = 0; p < 3; p++) begin
                ra    = (p == 2) ? 5'd6 : 5'd5;                // Pairs 5/5, 5/6, 6/5
                rb    = (p == 0) ? 5'd5 : 5'd6;
                r     = lcg_next();
                off   = {{19{r[12]}}, r[12:2], 2'b00};
                taken = branch_ref(f3, shadow[ra], shadow[rb]);
                base  = exp_pc;
                expect_no_write(enc_b(off[12:0], rb, ra, f3));
                exp_pc = taken ? base + off : base + 32'd4;
            end
        end
        r    = lcg_next();
        off  = {{11{r[20]}}, r[20:2], 2'b00};
        base = exp_pc;
        expect_write(enc_j(off[20:0], 5'd1), 5'd1, base + 32'd4);
        exp_pc = base + off;
        r = lcg_next();
        load_reg(5'd7, {r[31:2], 2'b00});
        r    = lcg_next();
        imm  = {r[11:2], 2'b01};                               // Odd target, bit 0 dropped
        base = exp_pc;
        expect_write(enc_i(imm, 5'd7, 3'b000, 5'd1, OPC_JALR), 5'd1, base + 32'd4);
        exp_pc = (shadow[7] + sext12(imm)) & ~32'd1;
        report("branch", start);
    endtask

    task automatic test_upper();
        int    start;
        word_t r;
        word_t base;
        start = errors;
        r = lcg_next();
        expect_write(enc_u(r[31:12], 5'd13, OPC_LUI), 5'd13, {r[31:12], 12'h000});
        r    = lcg_next();
        base = exp_pc;
        expect_write(enc_u(r[31:12], 5'd14, OPC_AUIPC), 5'd14, base + {r[31:12], 12'h000});
        report("upper", start);
    endtask

    task automatic test_memory();
        int          start;
        word_t       r;
        word_t       ew;
        logic [15:0] hw;
        logic [7:0]  bt;
        start = errors;
        for (int round = 0; round < 2; round++) begin
            r = lcg_next();
            load_reg(5'd8, {r[31:2], 2'b00});
            load_reg(5'd5, lcg_next());
            load_reg(5'd6, lcg_next());
            load_reg(5'd7, lcg_next());
            ew = shadow[5];
            expect_no_write(enc_s(12'd0, 5'd5, 5'd8, 3'b010));                    // SW
            expect_write(enc_i(12'd0, 5'd8, 3'b010, 5'd9, OPC_LOAD), 5'd9, ew);
            ew[31:16] = shadow[6][15:0];
            expect_no_write(enc_s(12'd2, 5'd6, 5'd8, 3'b001));                    // SH
            ew[15:8] = shadow[7][7:0];
            expect_no_write(enc_s(12'd1, 5'd7, 5'd8, 3'b000));                    // SB
            expect_write(enc_i(12'd0, 5'd8, 3'b010, 5'd9, OPC_LOAD), 5'd9, ew);
            for (int h = 0; h < 2; h++) begin
                hw = ew[16*h +: 16];
                expect_write(enc_i(12'(2 * h), 5'd8, 3'b001, 5'd9, OPC_LOAD), 5'd9,
                             {{16{hw[15]}}, hw});
                expect_write(enc_i(12'(2 * h), 5'd8, 3'b101, 5'd9, OPC_LOAD), 5'd9,
                             {16'h0000, hw});
            end
            for (int k = 0; k < 4; k++) begin
                bt = ew[8*k +: 8];
                expect_write(enc_i(12'(k), 5'd8, 3'b000, 5'd9, OPC_LOAD), 5'd9,
                             {{24{bt[7]}}, bt});
                expect_write(enc_i(12'(k), 5'd8, 3'b100, 5'd9, OPC_LOAD), 5'd9,
                             {24'h000000, bt});
            end
        end
        report("memory", start);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: tests still running after %0d cycles", cycles);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    initial begin
        reset  = 1'b1;
        instr  = NOP;
        exp_pc = `RESET_PC;
        test_reset();
        test_alu();
        test_x0();
        test_branch();
        test_upper();
        test_memory();
        errors = errors + UUT.u_chk.fails;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end
endmodule

//--- filelist.f
+incdir+src
src/rv_core_pkg.sv
src/fetch_unit.sv
src/instr_decoder.sv
src/register_file.sv
src/alu.sv
src/data_memory.sv
src/rv_core.sv
testbench/tb_clock.sv
testbench/rv_core_chk.sv
testbench/rv_core_tb.sv

//--- Makefile
TOP = rv_core_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f filelist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir
